//--- files.f
rtl/readout_pkg.sv
rtl/merge_if.sv
rtl/word_fifo.sv
rtl/trigger_unit.sv
rtl/readout_arbiter.sv
rtl/bus_regs.sv
rtl/readout_top.sv
bench/readout_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module readout_tb -f files.f -o readout_sim

# The simulator exits cleanly on both results, so the log decides
./obj_dir/readout_sim | tee sim.log

if grep -q "test passed" sim.log; then
    echo "simulation run: PASS"
    exit 0
fi
echo "simulation run: FAIL"
exit 1

//--- bench/readout_patterns.txt
# Columns: command, then hex arguments
# fe chan payload | burst mask count base | trig | veto level | idle cycles | wr addr data
# rd addr expected | fill | stall | drain trig_limit | test name
test chan_order
fe 0 000111
fe 2 000222
fe 3 000333
fe 1 000444
burst f 4 100000
drain 0
rd 04 00
test reg_ctrl
wr 00 5a
rd 00 5a
test trig_seq
wr 00 01
rd 00 01
trig
trig
trig
drain 0
rd 01 03
rd 02 00
test trig_off
wr 00 00
trig
veto 1
wr 00 01
trig
veto 0
idle 4
fill
drain 0
rd 01 03
test preempt
burst f c 200000
trig
idle 20
rd 04 20
drain 20
rd 01 04
test overflow
burst 4 20 300000
idle 10
rd 04 20
stall
burst 1 14 310000
rd 03 01
wr 03 00
rd 03 00
drain 0
test fill
fe 1 000aaa
fe 3 000bbb
fe 0 000ccc
trig
idle 8
fill
drain 0
rd 04 00
rd 01 05

//--- bench/readout_tb.sv
module readout_tb;
    import readout_pkg::*;

    localparam int cycles_per_line = 256;  // Bound for the longest command

    logic                 bus_clk;
    logic                 rst_n;
    logic [num_chan-1:0]  fe_valid;
    logic [fe_data_w-1:0] fe_data [num_chan];
    logic                 trigger_in;
    logic                 veto;
    logic                 busy;
    logic                 out_rd;
    readout_word_u        out_data;
    logic                 out_empty;
    logic [7:0]           reg_addr;
    logic [7:0]           reg_wdata;
    logic                 reg_wr;
    logic                 reg_rd;
    logic [7:0]           reg_rdata;

    // Reference model, one queue per source
    logic [fe_data_w-1:0]  chan_q [num_chan][$];
    logic [trig_num_w-1:0] trig_q [$];
    logic [trig_num_w-1:0] trig_next;
    logic                  trig_enabled;
    logic                  stalled;  // Output FIFO full, channel FIFOs empty
    int                    held [num_chan];

    string            test_name;
    logic [8*128-1:0] line_buf;
    int               fd;
    int               checks;
    int               errors;
    int               watchdog_cycles;

    readout_top readout_top_inst (
        .bus_clk    (bus_clk),
        .rst_n      (rst_n),
        .fe_valid   (fe_valid),
        .fe_data    (fe_data),
        .trigger_in (trigger_in),
        .veto       (veto),
        .busy       (busy),
        .out_rd     (out_rd),
        .out_data   (out_data),
        .out_empty  (out_empty),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_rdata  (reg_rdata)
    );

    initial begin
        bus_clk = 1'b0;
        forever #5 bus_clk = ~bus_clk;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge bus_clk);
        $display("Error: watchdog expired after %0d cycles, the run hung", watchdog_cycles);
        $display("test failed");
        $finish;
    end

    task automatic check_word(input string what, input readout_word_u exp,
                              input readout_word_u act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("Error: %s %s", test_name, msg);
    endtask

    // Token from $fscanf, right aligned with leading zero bytes
    function automatic string to_text(input logic [8*32-1:0] raw);
        string s;
        int i;
        s = "";
        for (i = 31; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) s = {s, $sformatf("%c", raw[i*8 +: 8])};
        end
        return s;
    endfunction

    function automatic int count_held_words();
        int total;
        int c;
        total = trig_q.size();
        for (c = 0; c < num_chan; c++) total += chan_q[c].size();
        return total;
    endfunction

    task automatic record_chan_word(input int c, input logic [fe_data_w-1:0] payload);
        // A stalled channel FIFO drops everything past its depth
        if (!stalled || held[c] < chan_fifo_depth) begin
            chan_q[c].push_back(payload);
            if (stalled) held[c]++;
        end
    endtask

    task automatic send_burst(input logic [num_chan-1:0] mask, input int count,
                              input logic [fe_data_w-1:0] base);
        int k;
        int c;
        for (k = 0; k < count; k++) begin
            @(negedge bus_clk);
            for (c = 0; c < num_chan; c++) begin
                fe_valid[c] = mask[c];
                fe_data[c]  = base + fe_data_w'(c * 32'h10000 + k);  // Channel in upper digits
                if (mask[c]) record_chan_word(c, fe_data[c]);
            end
        end
        @(negedge bus_clk);
        fe_valid = '0;
    endtask

    task automatic pulse_trigger();
        logic accepted;
        logic seen_busy;
        int k;
        accepted  = trig_enabled && !veto;
        seen_busy = 1'b0;
        if (accepted) begin
            trig_q.push_back(trig_next);
            trig_next = trig_next + 1'b1;
        end
        for (k = 0; k < 16; k++) begin
            @(negedge bus_clk);
            trigger_in = (k < 3);  // Long enough for the synchronizer
            if (busy) seen_busy = 1'b1;
        end
        check_flag("busy after trigger edge", accepted, seen_busy);
        check_flag("busy once the trigger word moved", 1'b0, busy);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(negedge bus_clk);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(negedge bus_clk);
        reg_wr = 1'b0;
        if (addr == reg_ctrl) trig_enabled = data[0];
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
        @(negedge bus_clk);
        reg_addr = addr;
        reg_rd   = 1'b1;
        @(negedge bus_clk);
        reg_rd = 1'b0;
        data   = reg_rdata;  // Captured at the edge after the strobe
    endtask

    task automatic drain_output(input int trig_limit);
        readout_word_u got;
        readout_word_u exp;
        int idle_cycles;
        int pos;
        int trig_pos;
        int fe_after;
        int chan;
        int c;
        idle_cycles = 0;
        pos         = 0;
        trig_pos    = -1;
        fe_after    = 0;
        while (idle_cycles < 8) begin
            @(negedge bus_clk);
            if (out_empty) begin
                out_rd = 1'b0;
                idle_cycles++;
            end else begin
                got         = out_data;
                out_rd      = 1'b1;
                idle_cycles = 0;
                exp         = '0;
                if (got.trig.marker) begin
                    if (trig_pos < 0) trig_pos = pos;
                    if (trig_q.size() == 0) begin
                        note_failure("a trigger word came out with none pending");
                    end else begin
                        exp.trig.marker = 1'b1;
                        exp.trig.number = trig_q.pop_front();
                        check_word("trigger word", exp, got);
                    end
                end else begin
                    if (trig_pos >= 0) fe_after++;
                    // Source channel found by payload among the queue heads
                    chan = -1;
                    for (c = num_chan - 1; c >= 0; c--) begin
                        if (chan_q[c].size() != 0 && chan_q[c][0] === got.fe.data) chan = c;
                    end
                    if (chan < 0) begin
                        note_failure($sformatf("channel word %h matches no pending word", got));
                    end else begin
                        exp.fe.chan_id = 7'(chan + 1);
                        exp.fe.data    = chan_q[chan].pop_front();
                        check_word("channel word", exp, got);
                    end
                end
                pos++;
            end
        end
        for (c = 0; c < num_chan; c++) begin
            if (chan_q[c].size() != 0)
                note_failure($sformatf("%0d words of channel %0d never came out",
                                       chan_q[c].size(), c));
        end
        if (trig_q.size() != 0) note_failure("some trigger words never came out");
        if (trig_limit > 0) begin
            if (trig_pos < 0)
                note_failure("no trigger word came out");
            else if (trig_pos >= trig_limit)
                note_failure($sformatf("trigger word only came out at position %0d", trig_pos));
            else if (fe_after == 0)
                note_failure("no channel backlog followed the trigger word");
        end
        stalled = 1'b0;
    endtask

    task automatic run_command(input string cmd);
        logic [31:0]     a1;
        logic [31:0]     a2;
        logic [31:0]     a3;
        logic [7:0]      rdata;
        logic [8*32-1:0] word_buf;
        int              n;
        int              c;
        if (cmd == "#") begin
            n = $fgets(line_buf, fd);
        end else if (cmd == "test") begin
            n = $fscanf(fd, "%s", word_buf);
            test_name = to_text(word_buf);
        end else if (cmd == "fe") begin
            n = $fscanf(fd, "%h %h", a1, a2);
            c = int'(a1);
            @(negedge bus_clk);
            fe_valid[c] = 1'b1;
            fe_data[c]  = a2[fe_data_w-1:0];
            record_chan_word(c, a2[fe_data_w-1:0]);
            @(negedge bus_clk);
            fe_valid = '0;
        end else if (cmd == "burst") begin
            n = $fscanf(fd, "%h %h %h", a1, a2, a3);
            send_burst(a1[num_chan-1:0], int'(a2), a3[fe_data_w-1:0]);
        end else if (cmd == "trig") begin
            pulse_trigger();
        end else if (cmd == "veto") begin
            n = $fscanf(fd, "%h", a1);
            @(negedge bus_clk);
            veto = a1[0];
        end else if (cmd == "idle") begin
            n = $fscanf(fd, "%h", a1);
            repeat (int'(a1)) @(negedge bus_clk);
        end else if (cmd == "wr") begin
            n = $fscanf(fd, "%h %h", a1, a2);
            write_reg(a1[7:0], a2[7:0]);
        end else if (cmd == "rd") begin
            n = $fscanf(fd, "%h %h", a1, a2);
            read_reg(a1[7:0], rdata);
            check_reg($sformatf("register %02h", a1[7:0]), a2[7:0], rdata);
        end else if (cmd == "fill") begin
            read_reg(reg_fill, rdata);
            check_reg("output fill", 8'(count_held_words()), rdata);
        end else if (cmd == "stall") begin
            stalled = 1'b1;
            held    = '{default: 0};
        end else if (cmd == "drain") begin
            n = $fscanf(fd, "%h", a1);
            drain_output(int'(a1));
        end else begin
            note_failure({"unknown pattern command ", cmd});
        end
    endtask

    initial begin
        logic [8*32-1:0] cmd_buf;
        int              n_lines;
        int              n;
        rst_n        = 1'b0;
        fe_valid     = '0;
        fe_data      = '{default: '0};
        trigger_in   = 1'b0;
        veto         = 1'b0;
        out_rd       = 1'b0;
        reg_addr     = 8'h00;
        reg_wdata    = 8'h00;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        checks       = 0;
        errors       = 0;
        trig_next    = '0;
        trig_enabled = 1'b0;  // Control register clears on reset
        stalled      = 1'b0;
        held         = '{default: 0};
        test_name    = "setup";
        n_lines      = 0;

        // First pass only sizes the watchdog
        fd = $fopen("bench/readout_patterns.txt", "r");
        if (fd != 0) begin
            while ($fgets(line_buf, fd) != 0) n_lines++;
            $fclose(fd);
            fd = $fopen("bench/readout_patterns.txt", "r");
        end
        watchdog_cycles = (n_lines + 2) * cycles_per_line;

        repeat (5) @(negedge bus_clk);
        check_flag("out_empty in reset", 1'b1, out_empty);
        check_flag("busy in reset", 1'b0, busy);
        rst_n = 1'b1;

        if (fd == 0) begin
            note_failure("cannot open bench/readout_patterns.txt");
        end else begin
            n = $fscanf(fd, "%s", cmd_buf);
            while (n == 1) begin
                run_command(to_text(cmd_buf));
                n = $fscanf(fd, "%s", cmd_buf);
            end
            $fclose(fd);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- rtl/readout_top.sv
module readout_top (
    input  logic                              bus_clk,
    input  logic                              rst_n,
    input  logic [readout_pkg::num_chan-1:0]  fe_valid,
    input  logic [readout_pkg::fe_data_w-1:0] fe_data [readout_pkg::num_chan],
    input  logic                              trigger_in,
    input  logic                              veto,
    output logic                              busy,
    input  logic                              out_rd,
    output readout_pkg::readout_word_u        out_data,
    output logic                              out_empty,
    input  logic [7:0]                        reg_addr,
    input  logic [7:0]                        reg_wdata,
    input  logic                              reg_wr,
    input  logic                              reg_rd,
    output logic [7:0]                        reg_rdata
);
    import readout_pkg::*;

    logic [num_chan-1:0]    chan_empty;
    logic [fe_data_w-1:0]   chan_data [num_chan];
    logic [num_chan-1:0]    chan_rd;
    logic [num_chan-1:0]    chan_ovf;
    logic                   trig_push;
    logic [trig_num_w-1:0]  trig_number;
    logic                   trig_full;
    logic                   trig_empty;
    logic [trig_num_w-1:0]  trig_data;
    logic                   trig_rd;
    logic                   trig_ovf;
    logic [15:0]            trig_count;
    logic                   trig_enable;
    logic [4:0]             clr_overflow;
    logic [out_level_w-1:0] out_level;

    merge_if merge ();

    // One FIFO per front-end channel
    for (genvar i = 0; i < num_chan; i++) begin : chan_gen
        word_fifo #(
            .width      (fe_data_w),
            .depth      (chan_fifo_depth),
            .near_level (chan_fifo_depth)
        ) chan_fifo (
            .bus_clk      (bus_clk),
            .rst_n        (rst_n),
            .wr           (fe_valid[i]),
            .wdata        (fe_data[i]),
            .rd           (chan_rd[i]),
            .rdata        (chan_data[i]),
            .empty        (chan_empty[i]),
            .full         (),
            .near_full    (),
            .level        (),
            .overflow     (chan_ovf[i]),
            .clr_overflow (clr_overflow[i])
        );
    end

    trigger_unit trigger_unit_inst (
        .bus_clk       (bus_clk),
        .rst_n         (rst_n),
        .trigger_in    (trigger_in),
        .veto          (veto),
        .enable        (trig_enable),
        .out_near_full (merge.near_full),
        .fifo_full     (trig_full),
        .push          (trig_push),
        .trig_number   (trig_number),
        .trig_count    (trig_count)
    );

    word_fifo #(
        .width      (trig_num_w),
        .depth      (trig_fifo_depth),
        .near_level (trig_fifo_depth)
    ) trig_fifo (
        .bus_clk      (bus_clk),
        .rst_n        (rst_n),
        .wr           (trig_push),
        .wdata        (trig_number),
        .rd           (trig_rd),
        .rdata        (trig_data),
        .empty        (trig_empty),
        .full         (trig_full),
        .near_full    (),
        .level        (),
        .overflow     (trig_ovf),
        .clr_overflow (clr_overflow[4])
    );

    assign busy = !trig_empty;  // High while trigger words wait

    readout_arbiter readout_arbiter_inst (
        .bus_clk    (bus_clk),
        .rst_n      (rst_n),
        .chan_empty (chan_empty),
        .chan_data  (chan_data),
        .chan_rd    (chan_rd),
        .trig_empty (trig_empty),
        .trig_data  (trig_data),
        .trig_rd    (trig_rd),
        .merge      (merge.arbiter)
    );

    word_fifo #(
        .width      ($bits(readout_word_u)),
        .depth      (out_fifo_depth),
        .near_level (out_near_full_level)
    ) out_fifo (
        .bus_clk      (bus_clk),
        .rst_n        (rst_n),
        .wr           (merge.wr),
        .wdata        (merge.word),
        .rd           (out_rd),
        .rdata        (out_data),
        .empty        (out_empty),
        .full         (merge.full),
        .near_full    (merge.near_full),
        .level        (out_level),
        .overflow     (),
        .clr_overflow (1'b0)
    );

    bus_regs bus_regs_inst (
        .bus_clk      (bus_clk),
        .rst_n        (rst_n),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_rdata    (reg_rdata),
        .trig_enable  (trig_enable),
        .trig_count   (trig_count),
        .overflow     ({trig_ovf, chan_ovf}),
        .clr_overflow (clr_overflow),
        .out_level    (out_level)
    );

endmodule

//--- rtl/bus_regs.sv
module bus_regs (
    input  logic                                bus_clk,
    input  logic                                rst_n,
    input  logic [7:0]                          reg_addr,
    input  logic [7:0]                          reg_wdata,
    input  logic                                reg_wr,
    input  logic                                reg_rd,
    output logic [7:0]                          reg_rdata,
    output logic                                trig_enable,
    input  logic [15:0]                         trig_count,
    input  logic [4:0]                          overflow,
    output logic [4:0]                          clr_overflow,
    input  logic [readout_pkg::out_level_w-1:0] out_level
);
    import readout_pkg::*;

    logic [7:0] ctrl;
    logic [7:0] rd_mux;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            ctrl <= 8'h00;  // Triggers start disabled
        end else if (reg_wr && reg_addr == reg_ctrl) begin
            ctrl <= reg_wdata;
        end
    end

    assign trig_enable = ctrl[0];

    // Any write to status clears every flag
    assign clr_overflow = {5{reg_wr && reg_addr == reg_status}};

    always_comb begin
        case (reg_addr)
            reg_ctrl:        rd_mux = ctrl;
            reg_trig_cnt_lo: rd_mux = trig_count[7:0];
            reg_trig_cnt_hi: rd_mux = trig_count[15:8];
            reg_status:      rd_mux = {3'b000, overflow};  // Bit 4 is the trigger FIFO
            reg_fill:        rd_mux = 8'(out_level);
            default:         rd_mux = 8'h00;
        endcase
    end

    // Read data one cycle after the strobe
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            reg_rdata <= 8'h00;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

//--- rtl/readout_arbiter.sv
module readout_arbiter (
    input  logic                               bus_clk,
    input  logic                               rst_n,
    input  logic [readout_pkg::num_chan-1:0]   chan_empty,
    input  logic [readout_pkg::fe_data_w-1:0]  chan_data [readout_pkg::num_chan],
    output logic [readout_pkg::num_chan-1:0]   chan_rd,
    input  logic                               trig_empty,
    input  logic [readout_pkg::trig_num_w-1:0] trig_data,
    output logic                               trig_rd,
    merge_if.arbiter                           merge
);
    import readout_pkg::*;

    localparam int sel_w = $clog2(num_chan);

    logic                room;
    logic                trig_grant;
    logic                chan_grant;
    logic [num_chan-1:0] chan_req;
    logic [sel_w-1:0]    sel;
    readout_word_u       next_word;

    // Word already in flight takes one of the last free slots
    assign room = !merge.full && !(merge.wr && merge.near_full);

    assign chan_req   = trig_empty ? ~chan_empty : '0;  // Channels masked behind triggers
    assign trig_grant = room && !trig_empty;
    assign chan_grant = room && (chan_req != '0);

    // Highest requesting index wins
    always_comb begin
        sel = '0;
        for (int i = 0; i < num_chan; i++) begin
            if (chan_req[i]) begin
                sel = sel_w'(i);
            end
        end
    end

    always_comb begin
        chan_rd = '0;
        if (chan_grant) begin
            chan_rd[sel] = 1'b1;
        end
    end

    assign trig_rd = trig_grant;

    always_comb begin
        next_word = '0;
        if (trig_grant) begin
            next_word.trig.marker = 1'b1;
            next_word.trig.number = trig_data;
        end else begin
            next_word.fe.marker  = 1'b0;
            next_word.fe.chan_id = 7'(sel) + 7'd1;  // Identifiers start at 1
            next_word.fe.data    = chan_data[sel];
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            merge.wr <= 1'b0;
        end else begin
            merge.wr <= trig_grant || chan_grant;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (trig_grant || chan_grant) begin
            merge.word <= next_word;
        end
    end

endmodule

//--- rtl/trigger_unit.sv
module trigger_unit (
    input  logic                               bus_clk,
    input  logic                               rst_n,
    input  logic                               trigger_in,
    input  logic                               veto,
    input  logic                               enable,
    input  logic                               out_near_full,
    input  logic                               fifo_full,
    output logic                               push,
    output logic [readout_pkg::trig_num_w-1:0] trig_number,
    output logic [15:0]                        trig_count
);
    logic [1:0]                        trig_sync;
    logic                              trig_prev;
    logic                              rise;
    logic                              accept;
    logic [readout_pkg::trig_num_w-1:0] num_next;

    // Two-stage synchronizer, then edge detect
    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            trig_sync <= 2'b00;
            trig_prev <= 1'b0;
        end else begin
            trig_sync <= {trig_sync[0], trigger_in};
            trig_prev <= trig_sync[1];
        end
    end

    assign rise   = trig_sync[1] && !trig_prev;
    assign accept = rise && enable && !veto && !out_near_full;

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            push       <= 1'b0;
            num_next   <= '0;
            trig_count <= '0;
        end else begin
            push <= accept;  // Word goes out the cycle after the edge
            if (accept) begin
                num_next   <= num_next + 1'b1;
                trig_count <= trig_count + 16'd1;
            end
        end
    end

    // Number of the pending push
    always_ff @(posedge bus_clk) begin
        if (accept) begin
            trig_number <= num_next;
        end
    end

    // A push meeting fifo_full still goes out, the FIFO records the loss

endmodule

//--- rtl/word_fifo.sv
module word_fifo #(
    parameter int width      = 32,
    parameter int depth      = 16,
    parameter int near_level = depth
) (
    input  logic                       bus_clk,
    input  logic                       rst_n,
    input  logic                       wr,
    input  logic [width-1:0]           wdata,
    input  logic                       rd,
    output logic [width-1:0]           rdata,
    output logic                       empty,
    output logic                       full,
    output logic                       near_full,
    output logic [$clog2(depth+1)-1:0] level,
    output logic                       overflow,
    input  logic                       clr_overflow
);
    localparam int addr_w  = $clog2(depth);
    localparam int level_w = $clog2(depth + 1);

    logic [width-1:0]   mem [depth];
    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [level_w-1:0] count;
    logic               do_wr;
    logic               do_rd;

    assign do_wr = wr && !full;  // Write into a full buffer is lost
    assign do_rd = rd && !empty;

    always_ff @(posedge bus_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, pointers wrap
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            if (clr_overflow) begin
                overflow <= 1'b0;
            end
            if (wr && full) begin
                overflow <= 1'b1;  // A new drop wins over a clear
            end
        end
    end

    // Show-ahead, head word always on the output
    assign rdata     = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == level_w'(depth));
    assign near_full = (count >= level_w'(near_level));
    assign level     = count;

endmodule

//--- rtl/merge_if.sv
// Write link from the arbiter into the output FIFO
interface merge_if;
    import readout_pkg::*;

    logic          wr;
    readout_word_u word;
    logic          full;
    logic          near_full;

    modport arbiter (
        output wr,
        output word,
        input  full,
        input  near_full
    );

    modport fifo (
        input  wr,
        input  word,
        output full,
        output near_full
    );

endinterface

//--- rtl/readout_pkg.sv
package readout_pkg;

    localparam int num_chan            = 4;
    localparam int fe_data_w           = 24;
    localparam int trig_num_w          = 31;
    localparam int chan_fifo_depth     = 16;
    localparam int trig_fifo_depth     = 8;
    localparam int out_fifo_depth      = 32;
    localparam int out_near_full_level = 28;
    localparam int out_level_w         = $clog2(out_fifo_depth + 1);

    // Front-end data word, marker 0
    typedef struct packed {
        logic                 marker;
        logic [6:0]           chan_id;  // Channel index plus 1
        logic [fe_data_w-1:0] data;
    } fe_word_t;

    // Trigger word, marker 1
    typedef struct packed {
        logic                  marker;
        logic [trig_num_w-1:0] number;
    } trig_word_t;

    // Bit 31 tells which view applies
    typedef union packed {
        fe_word_t   fe;
        trig_word_t trig;
    } readout_word_u;

    // Host register map
    localparam logic [7:0] reg_ctrl        = 8'h00;  // Bit 0 trigger enable
    localparam logic [7:0] reg_trig_cnt_lo = 8'h01;
    localparam logic [7:0] reg_trig_cnt_hi = 8'h02;
    localparam logic [7:0] reg_status      = 8'h03;  // Overflow flags, write clears
    localparam logic [7:0] reg_fill        = 8'h04;

endpackage
